// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_local_eject
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: project.f
+incdir+src
src/noc_pkg.sv
src/input_fifo.sv
src/l_rr_processor.sv
src/eject_unit.sv
src/local_eject_top.sv
testbench/tb_clock_gen.sv
testbench/tb_local_eject.sv

// File: src/eject_unit.sv
// pops and registers in the same edge; eject_data_o and eject_port_o are valid only with eject_valid_o
`include "noc_params.svh"

module eject_unit (
  input  logic                clk,
  input  logic                reset_i,
  input  logic [3:0]          grant_i,
  input  noc_pkg::port_sel_t  port_sel_i,
  input  noc_pkg::flit_data_t n_data_i,
  input  noc_pkg::flit_data_t s_data_i,
  input  noc_pkg::flit_data_t w_data_i,
  input  noc_pkg::flit_data_t e_data_i,
  input  logic                eject_ready_i,
  output logic [3:0]          pop_o,
  output logic                change_order_o,
  output logic                eject_valid_o,
  output noc_pkg::flit_data_t eject_data_o,
  output noc_pkg::port_sel_t  eject_port_o
);

  noc_pkg::flit_data_t sel_data;

  logic take;

  // crossbar column for the local output
  always_comb begin
    case (port_sel_i)
      `NOC_PORT_N: sel_data = n_data_i;
      `NOC_PORT_S: sel_data = s_data_i;
      `NOC_PORT_W: sel_data = w_data_i;
      `NOC_PORT_E: sel_data = e_data_i;
      default:     sel_data = n_data_i;
    endcase
  end

  // a flit leaves only when the sink can take it
  assign take           = (grant_i != 4'b0000) && eject_ready_i;
  assign pop_o          = grant_i & {4{eject_ready_i}};
  assign change_order_o = take;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      eject_valid_o <= 1'b0;
    end else begin
      eject_valid_o <= take;
    end
  end

  // payload and source held until the next ejection
  always_ff @(posedge clk) begin
    if (take) begin
      eject_data_o <= sel_data;
      eject_port_o <= port_sel_i;
    end
  end

endmodule

// File: src/input_fifo.sv
// writes while full and pops while empty are dropped; head is valid the cycle after its write
`include "noc_params.svh"

module input_fifo #(
  parameter int DEPTH = `NOC_FIFO_DEPTH
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               wr_i,
  input  noc_pkg::nexthop_t  wr_hop_i,
  input  noc_pkg::flit_data_t wr_data_i,
  output logic               full_o,
  input  logic               pop_i,
  output logic               head_valid_o,
  output noc_pkg::nexthop_t  head_hop_o,
  output noc_pkg::flit_data_t head_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // next hop and payload stored side by side
  noc_pkg::nexthop_t   hop_mem  [DEPTH];
  noc_pkg::flit_data_t data_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic do_wr;
  logic do_pop;

  assign full_o       = (count == CNT_W'(DEPTH));
  assign head_valid_o = (count != '0);
  assign do_wr        = wr_i && !full_o;
  assign do_pop       = pop_i && head_valid_o;

  // oldest entry is always at the read pointer
  assign head_hop_o  = hop_mem[rd_ptr];
  assign head_data_o = data_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      hop_mem[wr_ptr]  <= wr_hop_i;
      data_mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // explicit wrap so any depth works
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: src/l_rr_processor.sv
// grant is combinational from heads and order; port_sel_o is only meaningful while grant_o is non-zero
`include "noc_params.svh"

module l_rr_processor (
  input  logic              clk,
  input  logic              reset_i,
  input  noc_pkg::nexthop_t n_hop_i,
  input  noc_pkg::nexthop_t s_hop_i,
  input  noc_pkg::nexthop_t w_hop_i,
  input  noc_pkg::nexthop_t e_hop_i,
  input  logic              n_valid_i,
  input  logic              s_valid_i,
  input  logic              w_valid_i,
  input  logic              e_valid_i,
  input  logic              change_order_i,
  output logic [3:0]        grant_o,
  output noc_pkg::port_sel_t port_sel_o
);

  // bit layout matches the order register
  logic [3:0] desire;

  noc_pkg::rr_order_t order_q;

  logic [1:0] start_idx;

  // only heads addressed to this node may request
  assign desire[3] = n_valid_i && (n_hop_i == `NOC_HOP_L);
  assign desire[2] = s_valid_i && (s_hop_i == `NOC_HOP_L);
  assign desire[1] = w_valid_i && (w_hop_i == `NOC_HOP_L);
  assign desire[0] = e_valid_i && (e_hop_i == `NOC_HOP_L);

  // rotate north, south, west, east, back to north
  always_ff @(posedge clk) begin
    if (reset_i) begin
      order_q <= 4'b1000;
    end else if (change_order_i) begin
      order_q <= {order_q[0], order_q[3:1]};
    end
  end

  // index of the highest priority link
  always_comb begin
    start_idx = 2'd3;
    for (int i = 0; i < 4; i++) begin
      if (order_q[i]) begin
        start_idx = 2'(i);
      end
    end
  end

  // scan downward from the start bit with wrap, first desire wins
  always_comb begin
    logic [1:0] idx;
    logic       found;
    grant_o = 4'b0000;
    found   = 1'b0;
    idx     = start_idx;
    for (int k = 0; k < 4; k++) begin
      idx = start_idx - 2'(k);
      if (!found && desire[idx]) begin
        grant_o[idx] = 1'b1;
        found        = 1'b1;
      end
    end
  end

  // one-hot grant to source link code
  always_comb begin
    case (grant_o)
      4'b1000: port_sel_o = `NOC_PORT_N;
      4'b0100: port_sel_o = `NOC_PORT_S;
      4'b0010: port_sel_o = `NOC_PORT_W;
      4'b0001: port_sel_o = `NOC_PORT_E;
      default: port_sel_o = `NOC_PORT_N;
    endcase
  end

endmodule

// File: src/local_eject_top.sv
// local port only; a non-local head blocks its link since no other output arbiters exist
`include "noc_params.svh"

module local_eject_top (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                n_wr_i,
  input  noc_pkg::nexthop_t   n_hop_i,
  input  noc_pkg::flit_data_t n_data_i,
  output logic                n_full_o,
  input  logic                s_wr_i,
  input  noc_pkg::nexthop_t   s_hop_i,
  input  noc_pkg::flit_data_t s_data_i,
  output logic                s_full_o,
  input  logic                w_wr_i,
  input  noc_pkg::nexthop_t   w_hop_i,
  input  noc_pkg::flit_data_t w_data_i,
  output logic                w_full_o,
  input  logic                e_wr_i,
  input  noc_pkg::nexthop_t   e_hop_i,
  input  noc_pkg::flit_data_t e_data_i,
  output logic                e_full_o,
  input  logic                eject_ready_i,
  output logic                eject_valid_o,
  output noc_pkg::flit_data_t eject_data_o,
  output noc_pkg::port_sel_t  eject_port_o
);

  // fifo heads
  logic                n_head_valid;
  logic                s_head_valid;
  logic                w_head_valid;
  logic                e_head_valid;
  noc_pkg::nexthop_t   n_head_hop;
  noc_pkg::nexthop_t   s_head_hop;
  noc_pkg::nexthop_t   w_head_hop;
  noc_pkg::nexthop_t   e_head_hop;
  noc_pkg::flit_data_t n_head_data;
  noc_pkg::flit_data_t s_head_data;
  noc_pkg::flit_data_t w_head_data;
  noc_pkg::flit_data_t e_head_data;

  // arbiter and ejection handshake
  logic [3:0]         grant;
  logic [3:0]         pop;
  noc_pkg::port_sel_t port_sel;
  logic               change_order;

  // pop bits follow the order layout, north in bit 3
  input_fifo #(.DEPTH(`NOC_FIFO_DEPTH)) n_fifo_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .wr_i         (n_wr_i),
    .wr_hop_i     (n_hop_i),
    .wr_data_i    (n_data_i),
    .full_o       (n_full_o),
    .pop_i        (pop[3]),
    .head_valid_o (n_head_valid),
    .head_hop_o   (n_head_hop),
    .head_data_o  (n_head_data)
  );

  input_fifo #(.DEPTH(`NOC_FIFO_DEPTH)) s_fifo_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .wr_i         (s_wr_i),
    .wr_hop_i     (s_hop_i),
    .wr_data_i    (s_data_i),
    .full_o       (s_full_o),
    .pop_i        (pop[2]),
    .head_valid_o (s_head_valid),
    .head_hop_o   (s_head_hop),
    .head_data_o  (s_head_data)
  );

  input_fifo #(.DEPTH(`NOC_FIFO_DEPTH)) w_fifo_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .wr_i         (w_wr_i),
    .wr_hop_i     (w_hop_i),
    .wr_data_i    (w_data_i),
    .full_o       (w_full_o),
    .pop_i        (pop[1]),
    .head_valid_o (w_head_valid),
    .head_hop_o   (w_head_hop),
    .head_data_o  (w_head_data)
  );

  input_fifo #(.DEPTH(`NOC_FIFO_DEPTH)) e_fifo_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .wr_i         (e_wr_i),
    .wr_hop_i     (e_hop_i),
    .wr_data_i    (e_data_i),
    .full_o       (e_full_o),
    .pop_i        (pop[0]),
    .head_valid_o (e_head_valid),
    .head_hop_o   (e_head_hop),
    .head_data_o  (e_head_data)
  );

  l_rr_processor l_rr_processor_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .n_hop_i        (n_head_hop),
    .s_hop_i        (s_head_hop),
    .w_hop_i        (w_head_hop),
    .e_hop_i        (e_head_hop),
    .n_valid_i      (n_head_valid),
    .s_valid_i      (s_head_valid),
    .w_valid_i      (w_head_valid),
    .e_valid_i      (e_head_valid),
    .change_order_i (change_order),
    .grant_o        (grant),
    .port_sel_o     (port_sel)
  );

  eject_unit eject_unit_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .grant_i        (grant),
    .port_sel_i     (port_sel),
    .n_data_i       (n_head_data),
    .s_data_i       (s_head_data),
    .w_data_i       (w_head_data),
    .e_data_i       (e_head_data),
    .eject_ready_i  (eject_ready_i),
    .pop_o          (pop),
    .change_order_o (change_order),
    .eject_valid_o  (eject_valid_o),
    .eject_data_o   (eject_data_o),
    .eject_port_o   (eject_port_o)
  );

endmodule

// File: src/noc_params.svh
// all codes are 3-bit literals; next-hop code 4 means eject at this node, port codes cover links only
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// flit payload and buffering
`define NOC_FLIT_W      8
`define NOC_FIFO_DEPTH  4

// width of next-hop and port select codes
`define NOC_CODE_BITS   3

// next-hop codes carried in each flit
`define NOC_HOP_N  3'd0
`define NOC_HOP_S  3'd1
`define NOC_HOP_W  3'd2
`define NOC_HOP_E  3'd3
`define NOC_HOP_L  3'd4

// source link codes, also the crossbar select
`define NOC_PORT_N  3'd0
`define NOC_PORT_S  3'd1
`define NOC_PORT_W  3'd2
`define NOC_PORT_E  3'd3

`endif

// File: src/noc_pkg.sv
// types only; widths come from noc_params.svh, order vector is one-hot with north in bit 3
`include "noc_params.svh"

package noc_pkg;

  // next-hop code carried alongside each payload
  typedef logic [`NOC_CODE_BITS-1:0] nexthop_t;

  // crossbar select, names the source link of an ejected flit
  typedef logic [`NOC_CODE_BITS-1:0] port_sel_t;

  // flit payload
  typedef logic [`NOC_FLIT_W-1:0] flit_data_t;

  // rotating priority order
  // bit 3 north, bit 2 south, bit 1 west, bit 0 east
  // the set bit marks the highest priority link
  typedef logic [3:0] rr_order_t;

endpackage

// File: testbench/tb_clock_gen.sv
// free-running clock of period 4; reset_o is high through the first 3 rising edges
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // released on an edge so the DUT sees a clean synchronous deassert
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: testbench/tb_local_eject.sv
// drives local_eject_top with 4-deep FIFOs; outputs are checked on the falling edge against a cycle model
`include "noc_params.svh"

module tb_local_eject;

  localparam int ENTRY_W        = `NOC_CODE_BITS + `NOC_FLIT_W;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RANDOM_CYCLES  = 1200;

  logic clk;
  logic reset_i;

  // link inputs, index 3 is north down to 0 east
  logic                wr      [4];
  noc_pkg::nexthop_t   hop_in  [4];
  noc_pkg::flit_data_t data_in [4];
  logic                eject_ready;

  logic                n_full;
  logic                s_full;
  logic                w_full;
  logic                e_full;
  logic [3:0]          full_vec;
  logic                eject_valid_o;
  noc_pkg::flit_data_t eject_data_o;
  noc_pkg::port_sel_t  eject_port_o;

  // reference model state
  logic [ENTRY_W-1:0]  link_q [4][$];
  int                  model_count [4];
  int                  exp_ptr;
  logic                exp_valid;
  noc_pkg::flit_data_t exp_data;
  noc_pkg::port_sel_t  exp_port;
  logic [3:0]          exp_full;

  int          seed;
  int          cycle_count   = 0;
  int          eject_count   = 0;
  int          local_written = 0;
  logic [31:0] rnd;

  tb_clock_gen clock_gen_i (
    .clk_o   (clk),
    .reset_o (reset_i)
  );

  local_eject_top local_eject_top_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .n_wr_i        (wr[3]),
    .n_hop_i       (hop_in[3]),
    .n_data_i      (data_in[3]),
    .n_full_o      (n_full),
    .s_wr_i        (wr[2]),
    .s_hop_i       (hop_in[2]),
    .s_data_i      (data_in[2]),
    .s_full_o      (s_full),
    .w_wr_i        (wr[1]),
    .w_hop_i       (hop_in[1]),
    .w_data_i      (data_in[1]),
    .w_full_o      (w_full),
    .e_wr_i        (wr[0]),
    .e_hop_i       (hop_in[0]),
    .e_data_i      (data_in[0]),
    .e_full_o      (e_full),
    .eject_ready_i (eject_ready),
    .eject_valid_o (eject_valid_o),
    .eject_data_o  (eject_data_o),
    .eject_port_o  (eject_port_o)
  );

  assign full_vec = {n_full, s_full, w_full, e_full};

  task automatic fail_value(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "wrong value on %s", name);
  endtask

  // pops are decided on the state before the edge, writes land after it
  always @(posedge clk) begin : ref_model
    int                 idx;
    logic               found;
    logic [3:0]         was_full;
    logic [ENTRY_W-1:0] head;
    if (reset_i) begin
      for (int i = 0; i < 4; i++) begin
        link_q[i].delete();
        model_count[i] = 0;
      end
      exp_ptr   = 3;
      exp_valid = 1'b0;
      exp_full  = 4'b0000;
    end else begin
      exp_valid = 1'b0;
      found     = 1'b0;
      for (int i = 0; i < 4; i++) begin
        was_full[i] = (model_count[i] == `NOC_FIFO_DEPTH);
      end
      // first local head from the pointer, wrapping north, south, west, east
      if (eject_ready) begin
        for (int k = 0; k < 4; k++) begin
          idx = (exp_ptr - k + 4) % 4;
          if (!found && link_q[idx].size() != 0) begin
            head = link_q[idx][0];
            if (head[ENTRY_W-1:`NOC_FLIT_W] == `NOC_HOP_L) begin
              void'(link_q[idx].pop_front());
              found     = 1'b1;
              exp_valid = 1'b1;
              exp_data  = head[`NOC_FLIT_W-1:0];
              exp_port  = noc_pkg::port_sel_t'(3 - idx);
            end
          end
        end
        // one step per ejected flit
        if (found) begin
          exp_ptr = (exp_ptr + 3) % 4;
        end
      end
      for (int i = 0; i < 4; i++) begin
        if (wr[i] && !was_full[i]) begin
          link_q[i].push_back({hop_in[i], data_in[i]});
        end
        model_count[i] = link_q[i].size();
        exp_full[i]    = (model_count[i] == `NOC_FIFO_DEPTH);
      end
    end
  end

  a_valid: assert property (@(negedge clk) disable iff (reset_i) eject_valid_o == exp_valid)
    else fail_value("eject_valid_o", 32'(exp_valid), 32'(eject_valid_o));
  a_data: assert property (@(negedge clk) disable iff (reset_i)
    !exp_valid || (eject_data_o == exp_data))
    else fail_value("eject_data_o", 32'(exp_data), 32'(eject_data_o));
  a_port: assert property (@(negedge clk) disable iff (reset_i)
    !exp_valid || (eject_port_o == exp_port))
    else fail_value("eject_port_o", 32'(exp_port), 32'(eject_port_o));
  a_full: assert property (@(negedge clk) disable iff (reset_i) full_vec == exp_full)
    else fail_value("{n,s,w,e}_full_o", 32'(exp_full), 32'(full_vec));

  always @(negedge clk) begin
    if (!reset_i && eject_valid_o) begin
      eject_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // one stimulus cycle, a masked link writes only if its FIFO has room
  task automatic drive_cycle(input logic [3:0] wr_mask, input logic [3:0] local_mask,
                             input logic ready);
    logic [3:0]  go;
    logic [31:0] r;
    @(negedge clk);
    // count the write that is still in flight
    for (int i = 0; i < 4; i++) begin
      go[i] = wr_mask[i] && (model_count[i] + int'(wr[i]) < `NOC_FIFO_DEPTH);
    end
    @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      wr[i]      <= go[i];
      hop_in[i]  <= local_mask[i] ? `NOC_HOP_L : `NOC_HOP_E;
      data_in[i] <= r[`NOC_FLIT_W-1:0];
      if (go[i] && local_mask[i]) begin
        local_written++;
      end
    end
    eject_ready <= ready;
  endtask

  // idle with the sink ready until the given links are empty
  task automatic wait_drain(input logic [3:0] links);
    logic busy;
    busy = 1'b1;
    while (busy) begin
      drive_cycle(4'b0000, 4'b0000, 1'b1);
      @(negedge clk);
      busy = exp_valid;
      for (int i = 0; i < 4; i++) begin
        if (links[i] && model_count[i] != 0) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  initial begin
    seed = 32'h1576f523;
    for (int i = 0; i < 4; i++) begin
      wr[i]      = 1'b0;
      hop_in[i]  = `NOC_HOP_L;
      data_in[i] = '0;
    end
    eject_ready = 1'b0;
    @(negedge clk);
    while (reset_i) begin
      @(negedge clk);
    end
    // quiet after reset
    repeat (2) drive_cycle(4'b0000, 4'b0000, 1'b1);
    // one local flit per link, sink ready
    for (int i = 3; i >= 0; i--) begin
      drive_cycle(4'(1 << i), 4'b1111, 1'b1);
      wait_drain(4'b1111);
    end
    // all links loaded while the sink stalls, then released
    repeat (2) drive_cycle(4'b1111, 4'b1111, 1'b0);
    repeat (3) drive_cycle(4'b0000, 4'b0000, 1'b0);
    wait_drain(4'b1111);
    // stall in the middle of a stream
    repeat (3) drive_cycle(4'b1111, 4'b1111, 1'b1);
    repeat (4) drive_cycle(4'b0000, 4'b0000, 1'b0);
    wait_drain(4'b1111);
    // random local traffic, sink ready about three cycles in four
    repeat (RANDOM_CYCLES) begin
      rnd = $random(seed);
      drive_cycle(rnd[3:0], 4'b1111, rnd[5:4] != 2'b00);
    end
    wait_drain(4'b1111);
    a_count: assert (eject_count == local_written)
      else fail_value("ejected flit count", 32'(local_written), 32'(eject_count));
    // west head is not local, so west blocks and fills while the rest drain
    drive_cycle(4'b1111, 4'b1101, 1'b1);
    repeat (3) drive_cycle(4'b1111, 4'b1111, 1'b1);
    wait_drain(4'b1101);
    repeat (4) drive_cycle(4'b0000, 4'b0000, 1'b1);
    $display("TEST PASSED");
    $finish;
  end

endmodule
